//--- Bender.yml
package:
  name: hemaia_mem_chip

sources:
  # Packages first, the data package imports the address package
  - mem_chip_addr_pkg.sv
  - mem_chip_data_pkg.sv
  - mem_chip_req_decode.sv
  - mem_chip_spm.sv
  - mem_chip_rsp_merge.sv
  - hemaia_mem_chip.sv
  - target: test
    files:
      - tb_hemaia_mem_chip.sv

//--- hemaia_mem_chip.sv
////////////////////////////////////////////////////////////
// HeMAiA memory chip, local path
// Request decode, narrow scratchpad and response merge
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hemaia_mem_chip (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  mem_chip_addr_pkg::chip_id_t  chip_id_i,
  // Request port
  input  logic                         req_valid_i,
  input  logic                         req_we_i,
  input  mem_chip_addr_pkg::addr_t     req_addr_i,
  input  mem_chip_data_pkg::data_t     req_wdata_i,
  input  mem_chip_data_pkg::strb_t     req_strb_i,
  // Response port
  output logic                         rsp_valid_o,
  output logic                         rsp_err_o,
  output mem_chip_data_pkg::data_t     rsp_rdata_o
);

  import mem_chip_data_pkg::*;

  logic      spm_valid;
  logic      spm_we;
  word_idx_t spm_idx;
  data_t     spm_wdata;
  strb_t     spm_strb;
  logic      miss_valid;
  logic      spm_rvalid;
  data_t     spm_rdata;

  ////////////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////////////

  mem_chip_req_decode i_mem_chip_req_decode (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .chip_id_i    (chip_id_i),
    .req_valid_i  (req_valid_i),
    .req_we_i     (req_we_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .req_strb_i   (req_strb_i),
    .spm_valid_o  (spm_valid),
    .spm_we_o     (spm_we),
    .spm_idx_o    (spm_idx),
    .spm_wdata_o  (spm_wdata),
    .spm_strb_o   (spm_strb),
    .miss_valid_o (miss_valid)
  );

  ////////////////////////////////////////////////////////////
  // Narrow scratchpad
  ////////////////////////////////////////////////////////////

  mem_chip_spm i_mem_chip_spm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .spm_valid_i  (spm_valid),
    .spm_we_i     (spm_we),
    .spm_idx_i    (spm_idx),
    .spm_wdata_i  (spm_wdata),
    .spm_strb_i   (spm_strb),
    .spm_rvalid_o (spm_rvalid),
    .spm_rdata_o  (spm_rdata)
  );

  ////////////////////////////////////////////////////////////
  // Output side
  ////////////////////////////////////////////////////////////

  mem_chip_rsp_merge i_mem_chip_rsp_merge (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .miss_valid_i (miss_valid),
    .spm_rvalid_i (spm_rvalid),
    .spm_rdata_i  (spm_rdata),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_err_o    (rsp_err_o),
    .rsp_rdata_o  (rsp_rdata_o)
  );

endmodule

`default_nettype wire

//--- list.f
mem_chip_addr_pkg.sv
mem_chip_data_pkg.sv
mem_chip_req_decode.sv
mem_chip_spm.sv
mem_chip_rsp_merge.sv
hemaia_mem_chip.sv
tb_hemaia_mem_chip.sv

//--- mem_chip_addr_pkg.sv
////////////////////////////////////////////////////////////
// Memory chip address map
// Request address layout and the local scratchpad window
////////////////////////////////////////////////////////////

`default_nettype none

package mem_chip_addr_pkg;

  ////////////////////////////////////////////////////////////
  // Address layout
  ////////////////////////////////////////////////////////////

  // Chip ID sits in the top bits of every flat address
  localparam int unsigned AddrWidth   = 48;
  localparam int unsigned ChipIdWidth = 8;
  localparam int unsigned OffsetWidth = AddrWidth - ChipIdWidth;

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [ChipIdWidth-1:0] chip_id_t;
  typedef logic [OffsetWidth-1:0] offset_t;

  ////////////////////////////////////////////////////////////
  // Local address map
  ////////////////////////////////////////////////////////////

  // Narrow scratchpad window, base is aligned to its size
  localparam offset_t     NarrowSpmBase  = 40'h00_7000_0000;
  localparam int unsigned NarrowSpmBytes = 32'h0000_8000;

endpackage

`default_nettype wire

//--- mem_chip_data_pkg.sv
////////////////////////////////////////////////////////////
// Memory chip data path
// Word, strobe and index types of the narrow scratchpad
////////////////////////////////////////////////////////////

`default_nettype none

package mem_chip_data_pkg;

  import mem_chip_addr_pkg::*;

  localparam int unsigned DataWidth    = 64;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  localparam int unsigned ByteWidth    = DataWidth / StrbWidth;
  localparam int unsigned ByteOffWidth = $clog2(StrbWidth);

  // Scratchpad depth follows from the window size
  localparam int unsigned SpmWords     = NarrowSpmBytes / StrbWidth;
  localparam int unsigned WordIdxWidth = $clog2(SpmWords);

  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [StrbWidth-1:0]    strb_t;
  typedef logic [WordIdxWidth-1:0] word_idx_t;

endpackage

`default_nettype wire

//--- mem_chip_req_decode.sv
////////////////////////////////////////////////////////////
// Memory chip request decoder
// Holds the chip ID seen in reset and routes each request
// to the scratchpad or to the error path
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_chip_req_decode (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  mem_chip_addr_pkg::chip_id_t   chip_id_i,
  // Request strobe and payload
  input  logic                          req_valid_i,
  input  logic                          req_we_i,
  input  mem_chip_addr_pkg::addr_t      req_addr_i,
  input  mem_chip_data_pkg::data_t      req_wdata_i,
  input  mem_chip_data_pkg::strb_t      req_strb_i,
  // Scratchpad access
  output logic                          spm_valid_o,
  output logic                          spm_we_o,
  output mem_chip_data_pkg::word_idx_t  spm_idx_o,
  output mem_chip_data_pkg::data_t      spm_wdata_o,
  output mem_chip_data_pkg::strb_t      spm_strb_o,
  // Request that hits nothing
  output logic                          miss_valid_o
);

  import mem_chip_addr_pkg::*;
  import mem_chip_data_pkg::*;

  chip_id_t chip_id_q;
  chip_id_t req_chip_id;
  offset_t  req_offset;
  logic     id_match;
  logic     in_window;
  logic     req_hit;

  ////////////////////////////////////////////////////////////
  // Chip ID capture
  ////////////////////////////////////////////////////////////

  // Follows the pin while reset is held, frozen afterwards
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      chip_id_q <= chip_id_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  assign req_chip_id = req_addr_i[AddrWidth-1 -: ChipIdWidth];
  assign req_offset  = req_addr_i[OffsetWidth-1:0];

  assign id_match  = (req_chip_id == chip_id_q);
  assign in_window = (req_offset >= NarrowSpmBase) &&
                     (req_offset < NarrowSpmBase + offset_t'(NarrowSpmBytes));
  assign req_hit   = id_match && in_window;

  // Exactly one of the two strobes per request
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      spm_valid_o  <= 1'b0;
      miss_valid_o <= 1'b0;
    end else begin
      spm_valid_o  <= req_valid_i & req_hit;
      miss_valid_o <= req_valid_i & ~req_hit;
    end
  end

  // Window base is size aligned, so the index is a plain slice
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_hit) begin
      spm_we_o    <= req_we_i;
      spm_idx_o   <= req_offset[ByteOffWidth +: WordIdxWidth];
      spm_wdata_o <= req_wdata_i;
      spm_strb_o  <= req_strb_i;
    end
  end

endmodule

`default_nettype wire

//--- mem_chip_rsp_merge.sv
////////////////////////////////////////////////////////////
// Response merger
// Delays misses to the scratchpad latency and forms one
// in-order response stream
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_chip_rsp_merge (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Miss strobe from the decoder
  input  logic                      miss_valid_i,
  // Completion from the scratchpad
  input  logic                      spm_rvalid_i,
  input  mem_chip_data_pkg::data_t  spm_rdata_i,
  // Response port
  output logic                      rsp_valid_o,
  output logic                      rsp_err_o,
  output mem_chip_data_pkg::data_t  rsp_rdata_o
);

  logic miss_d1_q;
  logic miss_d2_q;

  ////////////////////////////////////////////////////////////
  // Miss delay line
  ////////////////////////////////////////////////////////////

  // Two stages, same as the scratchpad input and output registers
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      miss_d1_q <= 1'b0;
      miss_d2_q <= 1'b0;
    end else begin
      miss_d1_q <= miss_valid_i;
      miss_d2_q <= miss_d1_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // Merge
  ////////////////////////////////////////////////////////////

  // Both paths have equal latency and the decoder raises one
  // strobe per request, so the two never collide here
  assign rsp_valid_o = spm_rvalid_i | miss_d2_q;
  assign rsp_err_o   = miss_d2_q;

  // Error responses carry no data
  assign rsp_rdata_o = miss_d2_q ? '0 : spm_rdata_i;

endmodule

`default_nettype wire

//--- mem_chip_spm.sv
////////////////////////////////////////////////////////////
// Narrow scratchpad
// Single-port word array with byte strobes, registered on
// its input and on its output
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_chip_spm (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Access from the decoder
  input  logic                          spm_valid_i,
  input  logic                          spm_we_i,
  input  mem_chip_data_pkg::word_idx_t  spm_idx_i,
  input  mem_chip_data_pkg::data_t      spm_wdata_i,
  input  mem_chip_data_pkg::strb_t      spm_strb_i,
  // Completion, one per access
  output logic                          spm_rvalid_o,
  output mem_chip_data_pkg::data_t      spm_rdata_o
);

  import mem_chip_data_pkg::*;

  logic      in_valid_q;
  logic      in_we_q;
  word_idx_t in_idx_q;
  data_t     in_wdata_q;
  strb_t     in_strb_q;

  data_t     mem_q [SpmWords];

  ////////////////////////////////////////////////////////////
  // Input pipeline
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      in_valid_q <= 1'b0;
    end else begin
      in_valid_q <= spm_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (spm_valid_i) begin
      in_we_q    <= spm_we_i;
      in_idx_q   <= spm_idx_i;
      in_wdata_q <= spm_wdata_i;
      in_strb_q  <= spm_strb_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Array access into the output register
  ////////////////////////////////////////////////////////////

  // Read sees the word before this edge, later writes land after it
  always_ff @(posedge clk_i) begin
    if (in_valid_q) begin
      if (in_we_q) begin
        for (int unsigned b = 0; b < StrbWidth; b++) begin
          if (in_strb_q[b]) begin
            mem_q[in_idx_q][b*ByteWidth +: ByteWidth] <= in_wdata_q[b*ByteWidth +: ByteWidth];
          end
        end
      end else begin
        spm_rdata_o <= mem_q[in_idx_q];
      end
    end
  end

  // Writes complete too, so the merger sees every access
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      spm_rvalid_o <= 1'b0;
    end else begin
      spm_rvalid_o <= in_valid_q;
    end
  end

endmodule

`default_nettype wire

//--- tb_hemaia_mem_chip.sv
////////////////////////////////////////////////////////////
// Memory chip testbench
// Reference scratchpad model, LFSR stimulus, in-order checks
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_hemaia_mem_chip;

  import mem_chip_addr_pkg::*;
  import mem_chip_data_pkg::*;

  typedef struct packed {
    logic        err;
    logic        rd;
    data_t       data;
    strb_t       known;
    logic [31:0] cyc;
  } exp_t;

  localparam chip_id_t ChipId  = 8'h2a;
  localparam chip_id_t OtherId = 8'h5b;

  logic     clk_i;
  logic     rst_ni;
  chip_id_t chip_id_i;
  logic     req_valid_i;
  logic     req_we_i;
  addr_t    req_addr_i;
  data_t    req_wdata_i;
  strb_t    req_strb_i;
  logic     rsp_valid_o;
  logic     rsp_err_o;
  data_t    rsp_rdata_o;

  data_t       ref_mem   [SpmWords];
  strb_t       ref_known [SpmWords];
  exp_t        exp_q [$];
  string       name_q [$];
  string       test_name = "reset";
  logic [31:0] lfsr_state = 32'hbe76_9428;
  logic [31:0] cycle_cnt = '0;
  int unsigned data_errs = 0;
  int unsigned flag_errs = 0;
  int unsigned timing_errs = 0;
  int unsigned proto_errs = 0;

  hemaia_mem_chip hemaia_mem_chip_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      val = {val[62:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return val;
  endfunction

  // Returns the error flag, fills read data and its known bytes
  function automatic logic ref_access(input logic we, input addr_t addr, input data_t wdata,
                                      input strb_t strb, output data_t rdata,
                                      output strb_t known);
    offset_t   off;
    logic      hit;
    word_idx_t idx;
    off   = addr[OffsetWidth-1:0];
    hit   = (addr[AddrWidth-1 -: ChipIdWidth] == ChipId) && (off >= NarrowSpmBase) &&
            (off < NarrowSpmBase + offset_t'(NarrowSpmBytes));
    idx   = word_idx_t'((off - NarrowSpmBase) / StrbWidth);
    rdata = '0;
    known = '0;
    if (hit && we) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (strb[b]) begin
          ref_mem[idx][b*ByteWidth +: ByteWidth] = wdata[b*ByteWidth +: ByteWidth];
          ref_known[idx][b] = 1'b1;
        end
      end
    end else if (hit) begin
      rdata = ref_mem[idx];
      known = ref_known[idx];
    end
    return !hit;
  endfunction

  // Mostly hits in a small index range, so reads find earlier writes
  function automatic addr_t rand_addr();
    logic [1:0] kind;
    logic       wrong_id;
    chip_id_t   id;
    offset_t    off;
    kind     = rand_bits(2);
    wrong_id = rand_bits(1);
    id       = ChipId;
    off      = NarrowSpmBase + offset_t'(rand_bits(6) << 3);
    off      = off + offset_t'(rand_bits(3));
    if (kind == 2'd3 && wrong_id) begin
      id = ChipId ^ chip_id_t'({rand_bits(7), 1'b1});
    end else if (kind == 2'd3) begin
      off = off + offset_t'(NarrowSpmBytes) + offset_t'(rand_bits(16) << 6);
    end
    return {id, off};
  endfunction

  task automatic check_data(input string name, input data_t exp, input data_t act,
                            input strb_t known);
    data_t mask;
    for (int b = 0; b < StrbWidth; b++) begin
      mask[b*ByteWidth +: ByteWidth] = {ByteWidth{known[b]}};
    end
    if (((exp ^ act) & mask) !== '0) begin
      $display("[ERROR] %s: rdata expected %h actual %h", name, exp & mask, act);
      data_errs++;
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: rsp_err expected %b actual %b", name, exp, act);
      flag_errs++;
    end
  endtask

  task automatic check_cycle(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: response cycle expected %0d actual %0d", name, exp, act);
      timing_errs++;
    end
  endtask

  // Called 1 ns after an edge, the request is sampled on the next one
  task automatic send_req(input logic we, input addr_t addr, input data_t wdata,
                          input strb_t strb);
    exp_t e;
    e.err = ref_access(we, addr, wdata, strb, e.data, e.known);
    e.rd  = !we;
    e.cyc = cycle_cnt + 3;
    exp_q.push_back(e);
    name_q.push_back(test_name);
    req_valid_i = 1'b1;
    req_we_i    = we;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_strb_i  = strb;
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  always @(negedge clk_i) begin : compare_rsp
    exp_t  e;
    string nm;
    if (rst_ni && rsp_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("%s: response arrived with no request outstanding", test_name);
        proto_errs++;
      end else begin
        e  = exp_q.pop_front();
        nm = name_q.pop_front();
        check_cycle(nm, e.cyc, cycle_cnt);
        check_err(nm, e.err, rsp_err_o);
        if (e.rd && !e.err) check_data(nm, e.data, rsp_rdata_o, e.known);
      end
    end else if (rst_ni && (rsp_valid_o !== 1'b0 || rsp_err_o !== 1'b0)) begin
      $display("%s: response outputs not low while idle", test_name);
      proto_errs++;
    end
  end

  initial begin
    addr_t       a;
    logic        we;
    data_t       wd;
    strb_t       st;
    int unsigned wait_cnt;
    rst_ni      = 1'b0;
    chip_id_i   = ChipId;
    req_valid_i = 1'b0;
    req_we_i    = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_strb_i  = '0;
    for (int i = 0; i < SpmWords; i++) ref_known[i] = '0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    test_name = "idle";
    repeat (10) @(posedge clk_i);
    #1;

    test_name = "write_read";
    a = {ChipId, NarrowSpmBase + offset_t'(40'h128)};
    send_req(1'b1, a, 64'h0123_4567_89ab_cdef, 8'hff);
    send_req(1'b0, a, '0, '0);

    test_name = "partial_strobe";
    send_req(1'b1, a, 64'hffee_ddcc_bbaa_9988, 8'b0101_1010);
    send_req(1'b0, a, '0, '0);

    // Captured ID must survive a change on the pin
    test_name = "wrong_chip_id";
    chip_id_i = OtherId;
    send_req(1'b1, {OtherId, a[OffsetWidth-1:0]}, '1, 8'hff);
    send_req(1'b0, {OtherId, a[OffsetWidth-1:0]}, '0, '0);
    send_req(1'b0, a, '0, '0);

    // Both offsets alias the word of a if the window bound is ignored
    test_name = "outside_window";
    send_req(1'b1, {ChipId, a[OffsetWidth-1:0] + offset_t'(NarrowSpmBytes)}, '1, 8'hff);
    send_req(1'b1, {ChipId, a[OffsetWidth-1:0] - offset_t'(NarrowSpmBytes)}, '1, 8'hff);
    send_req(1'b0, a, '0, '0);

    test_name = "random";
    for (int n = 0; n < 300; n++) begin
      we = rand_bits(1);
      a  = rand_addr();
      wd = rand_bits(64);
      st = rand_bits(8);
      send_req(we, a, wd, st);
    end

    wait_cnt = 0;
    while (exp_q.size() != 0 && wait_cnt < 50) begin
      @(posedge clk_i);
      wait_cnt++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected responses never arrived", exp_q.size());
      proto_errs++;
    end
    // Idle tail catches stray pulses
    test_name = "drain";
    repeat (5) @(posedge clk_i);

    $display("Errors: data %0d, flag %0d, timing %0d, protocol %0d",
             data_errs, flag_errs, timing_errs, proto_errs);
    if (data_errs + flag_errs + timing_errs + proto_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
